// File: Bender.yml
package:
  name: pet_display

sources:
  - include_dirs:
      - .
    files:
      - pet_display_pkg.sv
      - pet_status_regs.sv
      - frame_scanner.sv
      - face_overlay.sv
      - action_overlay.sv
      - pet_display_top.sv
      - target: test
        files:
          - tb_pet_display.sv

// File: action_overlay.sv
//##################################################
// Second overlay stage: eat and heal marks over the
// face, then the pixel goes out on the stream
//##################################################
`default_nettype none
`timescale 1ns/1ps

`include "pet_display_defs.svh"

module action_overlay (
    input  logic                         clk_input_data,
    input  logic                         rst,
    input  pet_display_pkg::pixel_beat_t in_beat,
    input  logic                         in_valid,
    output logic                         in_ready,
    output logic [`PD_PIX_W-1:0]         pix_data,
    output logic                         pix_valid,
    input  logic                         pix_ready,
    output logic                         last_accepted
);

    logic [`PD_PIX_W-1:0]        paint;
    logic [`PD_PIX_W-1:0]        color_q;
    logic                        last_q;
    logic                        valid_q;
    logic                        load;
    logic [$clog2(`PD_ROWS)-1:0] row;
    logic [$clog2(`PD_COLS)-1:0] col;
    logic                        in_eat;
    logic                        in_heal;
    logic                        heal_bar;

    assign row = in_beat.row;
    assign col = in_beat.col;

    assign in_eat  = pet_display_pkg::in_span(row, `PD_EAT_ROW_LO, `PD_EAT_ROW_HI) &&
                     pet_display_pkg::in_span(col, `PD_EAT_COL_LO, `PD_EAT_COL_HI);
    assign in_heal = pet_display_pkg::in_span(row, `PD_HEAL_ROW_LO, `PD_HEAL_ROW_HI) &&
                     pet_display_pkg::in_span(col, `PD_HEAL_COL_LO, `PD_HEAL_COL_HI);
    // Vertical or horizontal bar of the plus shaped cross
    assign heal_bar = pet_display_pkg::in_span(col, `PD_HEAL_BAR_COL_LO, `PD_HEAL_BAR_COL_HI) ||
                      pet_display_pkg::in_span(row, `PD_HEAL_BAR_ROW_LO, `PD_HEAL_BAR_ROW_HI);

    always_comb begin
        paint = in_beat.color;
        if (in_beat.flags.eat && in_eat) begin
            paint = (col == `PD_EAT_COL_LO || col == `PD_EAT_COL_HI) ? `PD_BROWN : `PD_SKIN;
        end
        if (in_beat.flags.heal && in_heal) begin
            paint = heal_bar ? `PD_CROSS_GREEN : `PD_CROSS_BLUE;
        end
    end

    assign load          = !valid_q || pix_ready;
    assign in_ready      = load;
    assign pix_valid     = valid_q;
    assign pix_data      = color_q;
    assign last_accepted = valid_q && pix_ready && last_q;  // Closes the frame

    always_ff @(posedge clk_input_data) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk_input_data) begin
        if (load && in_valid) begin
            color_q <= paint;
            last_q  <= in_beat.last;
        end
    end

    a_hold_pix: assert property (@(posedge clk_input_data) disable iff (!rst)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix_data))
        else $error("pix_data changed or dropped while stalled");

endmodule

`default_nettype wire

// File: face_overlay.sv
//##################################################
// First overlay stage: eyes, cheeks, mouth and brows
// painted from the condition flags of each beat
//##################################################
`default_nettype none
`timescale 1ns/1ps

`include "pet_display_defs.svh"

module face_overlay (
    input  logic                         clk_input_data,
    input  logic                         rst,
    input  pet_display_pkg::pixel_beat_t in_beat,
    input  logic                         in_valid,
    output logic                         in_ready,
    output pet_display_pkg::pixel_beat_t out_beat,
    output logic                         out_valid,
    input  logic                         out_ready
);

    pet_display_pkg::pixel_beat_t paint;
    pet_display_pkg::pixel_beat_t beat_q;
    logic                         valid_q;
    logic                         load;
    logic [$clog2(`PD_ROWS)-1:0]  row;
    logic [$clog2(`PD_COLS)-1:0]  col;
    logic                         in_eye;
    logic                         in_cheek;
    logic                         in_mouth;
    logic                         in_brow;

    assign row = in_beat.row;
    assign col = in_beat.col;

    assign in_eye = (pet_display_pkg::in_span(row, `PD_EYE_ROW_A_LO, `PD_EYE_ROW_A_HI) ||
                     pet_display_pkg::in_span(row, `PD_EYE_ROW_B_LO, `PD_EYE_ROW_B_HI)) &&
                    pet_display_pkg::in_span(col, `PD_EYE_COL_LO, `PD_EYE_COL_HI);
    assign in_cheek = (pet_display_pkg::in_span(row, `PD_CHEEK_ROW_A_LO, `PD_CHEEK_ROW_A_HI) ||
                       pet_display_pkg::in_span(row, `PD_CHEEK_ROW_B_LO, `PD_CHEEK_ROW_B_HI)) &&
                      pet_display_pkg::in_span(col, `PD_CHEEK_COL_LO, `PD_CHEEK_COL_HI);
    assign in_mouth = pet_display_pkg::in_span(row, `PD_MOUTH_ROW_LO, `PD_MOUTH_ROW_HI) &&
                      (col == (in_beat.flags.sad ? `PD_MOUTH_COL_SAD : `PD_MOUTH_COL_OK));
    assign in_brow = pet_display_pkg::in_span(row, `PD_BROW_ROW_LO, `PD_BROW_ROW_HI) &&
                     pet_display_pkg::in_span(col, `PD_BROW_COL_LO, `PD_BROW_COL_HI);

    always_comb begin
        paint = in_beat;
        if (in_eye) begin
            if (in_beat.flags.hungry) begin
                paint.color = pet_display_pkg::in_span(col, `PD_PUPIL_COL_LO, `PD_PUPIL_COL_HI)
                              ? `PD_BLACK : `PD_SKIN;
            end else begin
                // Wide pupil with skin only on the outer columns
                paint.color = (col == `PD_EYE_COL_LO || col == `PD_EYE_COL_HI)
                              ? `PD_SKIN : `PD_BLACK;
            end
        end
        if (in_cheek) begin
            paint.color = in_beat.flags.sick ? `PD_YELLOW : `PD_GREEN;
        end
        if (in_mouth) begin
            paint.color = `PD_BLACK;
        end
        if (in_brow) begin
            paint.color = in_beat.flags.tired ? `PD_WHITE : `PD_BLACK;
        end
    end

    assign load      = !valid_q || out_ready;  // Empty or draining
    assign in_ready  = load;
    assign out_valid = valid_q;
    assign out_beat  = beat_q;

    always_ff @(posedge clk_input_data) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk_input_data) begin
        if (load && in_valid) begin
            beat_q <= paint;
        end
    end

endmodule

`default_nettype wire

// File: frame_scanner.sv
//##################################################
// Walks the pixel index of one frame after start and
// emits background beats carrying the flag snapshot
//##################################################
`default_nettype none
`timescale 1ns/1ps

`include "pet_display_defs.svh"

module frame_scanner (
    input  logic                         clk_input_data,
    input  logic                         rst,
    input  logic                         start,
    input  pet_display_pkg::pet_flags_t  flags,
    output logic                         busy,
    output pet_display_pkg::pixel_beat_t out_beat,
    output logic                         out_valid,
    input  logic                         out_ready,
    input  logic                         last_accepted,
    output logic                         frame_done
);

    logic [`PD_IDX_W-1:0]        idx_q;
    pet_display_pkg::pet_flags_t flags_q;
    logic                        at_last;
    logic                        advance;

    assign at_last = (idx_q == `PD_IDX_W'(`PD_PIXELS - 1));
    assign advance = out_valid && out_ready;

    always_ff @(posedge clk_input_data) begin
        if (!rst) begin
            busy       <= 1'b0;
            out_valid  <= 1'b0;
            idx_q      <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy      <= 1'b1;
                    out_valid <= 1'b1;  // Pixel 0 ready at once
                    idx_q     <= '0;
                end
            end else begin
                if (advance) begin
                    if (at_last) begin
                        out_valid <= 1'b0;  // Wait for the pipeline to drain
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                if (last_accepted) begin
                    busy       <= 1'b0;
                    frame_done <= 1'b1;
                end
            end
        end
    end

    // Flags are frozen for the whole frame
    always_ff @(posedge clk_input_data) begin
        if (start && !busy) begin
            flags_q <= flags;
        end
    end

    always_comb begin
        out_beat.row   = idx_q[`PD_IDX_W-1:$clog2(`PD_COLS)];
        out_beat.col   = idx_q[$clog2(`PD_COLS)-1:0];
        out_beat.color = `PD_BG_COLOR;
        out_beat.flags = flags_q;
        out_beat.last  = at_last;
    end

    a_hold_idx: assert property (@(posedge clk_input_data) disable iff (!rst)
        out_valid && !out_ready |=> out_valid && $stable(idx_q))
        else $error("pixel index moved while the scanner was stalled");

endmodule

`default_nettype wire

// File: pet_display.f
+incdir+.
pet_display_pkg.sv
pet_status_regs.sv
frame_scanner.sv
face_overlay.sv
action_overlay.sv
pet_display_top.sv
tb_pet_display.sv

// File: pet_display_defs.svh
//##################################################
// Frame size, APB register map, RGB565 colors and
// face geometry, included by every pet display file
//##################################################
`ifndef PET_DISPLAY_DEFS_SVH
`define PET_DISPLAY_DEFS_SVH

`define PD_COLS   128
`define PD_ROWS   128
`define PD_PIXELS 16384
`define PD_IDX_W  14
`define PD_PIX_W  16
`define PD_ADDR_W 4

`define PD_REG_STATUS 4'h0 // hungry, sick, sad, tired from bit 0 up
`define PD_REG_ACTION 4'h4 // eat, heal from bit 0 up
`define PD_REG_CTRL   4'h8 // Write bit 0 to start, read busy

`define PD_BG_COLOR    16'h7bef
`define PD_SKIN        16'hff14
`define PD_BLACK       16'h0000
`define PD_WHITE       16'hffff
`define PD_YELLOW      16'hfe32
`define PD_GREEN       16'h4dac
`define PD_BROWN       16'h91e4
`define PD_CROSS_GREEN 16'h4e8c
`define PD_CROSS_BLUE  16'h45bc

// Inclusive row and column bounds of the face features
`define PD_EYE_ROW_A_LO   7'd57
`define PD_EYE_ROW_A_HI   7'd59
`define PD_EYE_ROW_B_LO   7'd68
`define PD_EYE_ROW_B_HI   7'd70
`define PD_EYE_COL_LO     7'd76
`define PD_EYE_COL_HI     7'd81
`define PD_PUPIL_COL_LO   7'd78 // Narrow pupil when hungry
`define PD_PUPIL_COL_HI   7'd79
`define PD_CHEEK_ROW_A_LO 7'd53
`define PD_CHEEK_ROW_A_HI 7'd55
`define PD_CHEEK_ROW_B_LO 7'd72
`define PD_CHEEK_ROW_B_HI 7'd74
`define PD_CHEEK_COL_LO   7'd82
`define PD_CHEEK_COL_HI   7'd85
`define PD_MOUTH_ROW_LO   7'd58
`define PD_MOUTH_ROW_HI   7'd67
`define PD_MOUTH_COL_SAD  7'd88
`define PD_MOUTH_COL_OK   7'd86
`define PD_BROW_ROW_LO    7'd44
`define PD_BROW_ROW_HI    7'd46
`define PD_BROW_COL_LO    7'd55
`define PD_BROW_COL_HI    7'd60

// Action marks
`define PD_EAT_ROW_LO     7'd58
`define PD_EAT_ROW_HI     7'd69
`define PD_EAT_COL_LO     7'd86
`define PD_EAT_COL_HI     7'd89
`define PD_HEAL_ROW_LO    7'd61
`define PD_HEAL_ROW_HI    7'd66
`define PD_HEAL_COL_LO    7'd97
`define PD_HEAL_COL_HI    7'd102
`define PD_HEAL_BAR_ROW_LO 7'd63
`define PD_HEAL_BAR_ROW_HI 7'd64
`define PD_HEAL_BAR_COL_LO 7'd99
`define PD_HEAL_BAR_COL_HI 7'd100

`endif

// File: pet_display_pkg.sv
//##################################################
// Types passed between the pet display pipeline stages
//##################################################
`default_nettype none

`include "pet_display_defs.svh"

package pet_display_pkg;

    // Condition and action flags where 1 means present
    typedef struct packed {
        logic hungry;
        logic sick;
        logic sad;
        logic tired;
        logic eat;
        logic heal;
    } pet_flags_t;

    // One pixel travelling down the pipeline
    typedef struct packed {
        logic [$clog2(`PD_ROWS)-1:0] row;
        logic [$clog2(`PD_COLS)-1:0] col;
        logic [`PD_PIX_W-1:0]        color;
        pet_flags_t                  flags;
        logic                        last;  // Final pixel of the frame
    } pixel_beat_t;

    // Inclusive range check on a row or column
    function automatic logic in_span(
        input logic [$clog2(`PD_COLS)-1:0] v,
        input logic [$clog2(`PD_COLS)-1:0] lo,
        input logic [$clog2(`PD_COLS)-1:0] hi
    );
        return (v >= lo) && (v <= hi);
    endfunction

endpackage

`default_nettype wire

// File: pet_display_top.sv
//##################################################
// Pet display top: APB registers, frame scanner and
// two overlay stages feeding the pixel stream
//##################################################
`default_nettype none
`timescale 1ns/1ps

`include "pet_display_defs.svh"

module pet_display_top (
    input  logic                  clk_input_data,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`PD_ADDR_W-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic [`PD_PIX_W-1:0]  pix_data,
    output logic                  pix_valid,
    input  logic                  pix_ready,
    output logic                  frame_done
);

    pet_display_pkg::pet_flags_t  flags;
    pet_display_pkg::pixel_beat_t scan_beat;
    pet_display_pkg::pixel_beat_t face_beat;
    logic                         start;
    logic                         busy;
    logic                         scan_valid;
    logic                         scan_ready;
    logic                         face_valid;
    logic                         face_ready;
    logic                         last_accepted;

    pet_status_regs u_pet_status_regs (
        .clk_input_data, .rst,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .busy, .flags, .start
    );

    frame_scanner u_frame_scanner (
        .clk_input_data, .rst,
        .start, .flags, .busy,
        .out_beat  (scan_beat),
        .out_valid (scan_valid),
        .out_ready (scan_ready),
        .last_accepted,
        .frame_done
    );

    face_overlay u_face_overlay (
        .clk_input_data, .rst,
        .in_beat   (scan_beat),
        .in_valid  (scan_valid),
        .in_ready  (scan_ready),
        .out_beat  (face_beat),
        .out_valid (face_valid),
        .out_ready (face_ready)
    );

    action_overlay u_action_overlay (
        .clk_input_data, .rst,
        .in_beat   (face_beat),
        .in_valid  (face_valid),
        .in_ready  (face_ready),
        .pix_data, .pix_valid, .pix_ready,
        .last_accepted
    );

endmodule

`default_nettype wire

// File: pet_status_regs.sv
//##################################################
// APB slave with STATUS, ACTION and CTRL registers;
// a CTRL write of bit 0 pulses start to the scanner
//##################################################
`default_nettype none
`timescale 1ns/1ps

`include "pet_display_defs.svh"

module pet_status_regs (
    input  logic                        clk_input_data,
    input  logic                        rst,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`PD_ADDR_W-1:0]       paddr,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  logic                        busy,
    output pet_display_pkg::pet_flags_t flags,
    output logic                        start
);

    logic [3:0] status_q;  // hungry, sick, sad, tired
    logic [1:0] action_q;  // eat, heal
    logic       access;
    logic       addr_hit;

    assign access   = psel && penable;
    assign addr_hit = (paddr == `PD_REG_STATUS) || (paddr == `PD_REG_ACTION) ||
                      (paddr == `PD_REG_CTRL);
    assign pready   = 1'b1;             // No wait states
    assign pslverr  = access && !addr_hit;

    always_ff @(posedge clk_input_data) begin
        if (!rst) begin
            status_q <= '0;
            action_q <= '0;
            start    <= 1'b0;
        end else begin
            start <= 1'b0;
            if (access && pwrite) begin
                case (paddr)
                    `PD_REG_STATUS: status_q <= pwdata[3:0];
                    `PD_REG_ACTION: action_q <= pwdata[1:0];
                    `PD_REG_CTRL:   start    <= pwdata[0] && !busy; // Dropped mid-frame
                    default:        ;
                endcase
            end
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            `PD_REG_STATUS: prdata[3:0] = status_q;
            `PD_REG_ACTION: prdata[1:0] = action_q;
            `PD_REG_CTRL:   prdata[0]   = busy;
            default:        prdata      = '0;   // Unmapped reads zero
        endcase
    end

    assign flags = '{hungry: status_q[0],
                     sick:   status_q[1],
                     sad:    status_q[2],
                     tired:  status_q[3],
                     eat:    action_q[0],
                     heal:   action_q[1]};

    // Start reaches an idle scanner, which turns busy on the next edge
    a_start_idle: assert property (@(posedge clk_input_data) disable iff (!rst)
        start |-> !busy ##1 busy)
        else $error("start pulse while the scanner was busy or did not engage");

endmodule

`default_nettype wire

// File: tb_pet_display.sv
//##################################################
// Testbench for the pet display: APB stimulus, pixel
// reference model and assertion checks on the stream
//##################################################
`default_nettype none
`timescale 1ns/1ps

`include "pet_display_defs.svh"

module tb_pet_display;

    localparam int FRAME_LIMIT = `PD_PIXELS * 4;  // Cycles allowed for one frame
    localparam int WATCHDOG_NS = 4 * `PD_PIXELS * 4 * 10 + 100000;

    logic                        clk_input_data = 1'b0;
    logic                        rst;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`PD_ADDR_W-1:0]       paddr;
    logic [31:0]                 pwdata;
    logic [31:0]                 prdata;
    logic                        pready;
    logic                        pslverr;
    logic [`PD_PIX_W-1:0]        pix_data;
    logic                        pix_valid;
    logic                        pix_ready;
    logic                        frame_done;
    logic [15:0]                 lfsr;
    string                       test_name;
    logic [14:0]                 pix_count;     // Beats transferred in this frame
    logic                        frame_active;
    pet_display_pkg::pet_flags_t shadow_flags;  // Last values written over APB
    pet_display_pkg::pet_flags_t frame_flags;   // Flags latched at frame start
    logic [31:0]                 exp_rdata;
    logic                        exp_slverr;
    logic [`PD_PIX_W-1:0]        exp_color;

    pet_display_top u_pet_display_top (.*);

    always #5 clk_input_data = ~clk_input_data;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    // Pixel color from the face and action rules
    function automatic logic [15:0] expected_color(input logic [13:0] idx,
                                                   input pet_display_pkg::pet_flags_t f);
        int          row;
        int          col;
        logic [15:0] c;
        row = idx / 128;
        col = idx % 128;
        c   = `PD_BG_COLOR;
        if (row inside {[57:59], [68:70]} && col inside {[76:81]}) begin
            if (f.hungry)
                c = (col inside {[78:79]}) ? `PD_BLACK : `PD_SKIN;
            else
                c = (col inside {[77:80]}) ? `PD_BLACK : `PD_SKIN;
        end
        if (row inside {[53:55], [72:74]} && col inside {[82:85]})
            c = f.sick ? `PD_YELLOW : `PD_GREEN;
        if (row inside {[58:67]} && col == (f.sad ? 88 : 86))
            c = `PD_BLACK;
        if (row inside {[44:46]} && col inside {[55:60]})
            c = f.tired ? `PD_WHITE : `PD_BLACK;
        if (f.eat && row inside {[58:69]} && col inside {[86:89]})
            c = (col == 86 || col == 89) ? `PD_BROWN : `PD_SKIN;  // Eat covers the mouth
        if (f.heal && row inside {[61:66]} && col inside {[97:102]})
            c = (col inside {[99:100]} || row inside {[63:64]}) ? `PD_CROSS_GREEN : `PD_CROSS_BLUE;
        return c;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // On a read, data is the value prdata must show
    task automatic apb_access(input logic write, input logic [3:0] addr,
                              input logic [31:0] data);
        @(posedge clk_input_data);
        psel       <= 1'b1;
        penable    <= 1'b0;
        pwrite     <= write;
        paddr      <= addr;
        pwdata     <= write ? data : 32'h0;
        exp_rdata  <= write ? 32'h0 : data;
        exp_slverr <= !(addr inside {`PD_REG_STATUS, `PD_REG_ACTION, `PD_REG_CTRL});
        @(posedge clk_input_data);
        penable <= 1'b1;  // Access phase
        @(posedge clk_input_data);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_frame(input logic random_ready);
        int          cycles;
        logic [31:0] b;
        cycles = 0;
        do begin
            @(posedge clk_input_data);
            if (random_ready) begin
                random_bits(1, b);
                pix_ready <= b[0];
            end
            cycles++;
        end while (!frame_done && cycles <= FRAME_LIMIT);
        if (!frame_done)
            fail_run($sformatf("frame_done never arrived in test %s", test_name));
        pix_ready <= 1'b1;
    endtask

    // Reference state for beat count, register shadow and frame flags
    always @(posedge clk_input_data) begin
        if (!rst) begin
            pix_count    <= '0;
            frame_active <= 1'b0;
            shadow_flags <= '0;
            frame_flags  <= '0;
        end else begin
            if (frame_done) begin
                pix_count    <= '0;
                frame_active <= 1'b0;
            end else if (pix_valid && pix_ready) begin
                pix_count <= pix_count + 1'b1;
            end
            if (psel && penable && pwrite) begin
                case (paddr)
                    `PD_REG_STATUS: begin
                        shadow_flags.hungry <= pwdata[0];
                        shadow_flags.sick   <= pwdata[1];
                        shadow_flags.sad    <= pwdata[2];
                        shadow_flags.tired  <= pwdata[3];
                    end
                    `PD_REG_ACTION: begin
                        shadow_flags.eat  <= pwdata[0];
                        shadow_flags.heal <= pwdata[1];
                    end
                    `PD_REG_CTRL: begin
                        if (pwdata[0] && !frame_active) begin  // Ignored while busy
                            frame_active <= 1'b1;
                            frame_flags  <= shadow_flags;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    assign exp_color = expected_color(pix_count[13:0], frame_flags);

    a_pixel: assert property (@(posedge clk_input_data) disable iff (!rst)
        pix_valid && pix_ready |-> pix_data == exp_color)
        else fail_run($sformatf("MISMATCH %s pixel %0d: expected %h, actual %h", test_name,
                      $sampled(pix_count), $sampled(exp_color), $sampled(pix_data)));

    a_no_extra: assert property (@(posedge clk_input_data) disable iff (!rst)
        pix_valid && pix_ready |-> pix_count < `PD_PIXELS)
        else fail_run($sformatf("more than one frame of beats in test %s", test_name));

    a_done_after_last: assert property (@(posedge clk_input_data) disable iff (!rst)
        pix_valid && pix_ready && pix_count == `PD_PIXELS - 1 |=> frame_done)
        else fail_run($sformatf("frame_done missing after the last beat in %s", test_name));

    a_done_count: assert property (@(posedge clk_input_data) disable iff (!rst)
        frame_done |-> pix_count == `PD_PIXELS)
        else fail_run($sformatf("MISMATCH %s beat count: expected %0d, actual %0d",
                      test_name, `PD_PIXELS, $sampled(pix_count)));

    a_idle: assert property (@(posedge clk_input_data) disable iff (!rst)
        !frame_active |-> !pix_valid && !frame_done)
        else fail_run($sformatf("stream active without a started frame in %s", test_name));

    a_stall: assert property (@(posedge clk_input_data) disable iff (!rst)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix_data))
        else fail_run($sformatf("pixel dropped or changed under stall in %s", test_name));

    a_rdata: assert property (@(posedge clk_input_data) disable iff (!rst)
        psel && penable && !pwrite |-> prdata == exp_rdata)
        else fail_run($sformatf("MISMATCH %s prdata: expected %h, actual %h", test_name,
                      $sampled(exp_rdata), $sampled(prdata)));

    a_slverr: assert property (@(posedge clk_input_data) disable iff (!rst)
        pready && pslverr == (psel && penable && exp_slverr))
        else fail_run($sformatf("MISMATCH %s pslverr: expected %b, actual %b", test_name,
                      $sampled(psel && penable && exp_slverr), $sampled(pslverr)));

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before the tests completed");
    end

    initial begin
        logic [31:0] rnd;
        lfsr       = 16'd34815;
        rst        = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        pix_ready  = 1'b0;
        exp_rdata  = '0;
        exp_slverr = 1'b0;
        test_name  = "reset";
        repeat (16) @(posedge clk_input_data);
        rst <= 1'b1;
        apb_access(1'b0, `PD_REG_STATUS, 32'h0);
        apb_access(1'b0, `PD_REG_ACTION, 32'h0);
        apb_access(1'b0, `PD_REG_CTRL, 32'h0);

        test_name = "blank_face";
        pix_ready <= 1'b1;
        apb_access(1'b1, `PD_REG_CTRL, 32'h1);
        wait_frame(1'b0);
        apb_access(1'b0, `PD_REG_CTRL, 32'h0);  // Busy cleared

        test_name = "all_conditions";
        apb_access(1'b1, `PD_REG_STATUS, 32'hf);
        apb_access(1'b1, `PD_REG_CTRL, 32'h1);
        wait_frame(1'b0);

        test_name = "eat_and_heal";
        random_bits(4, rnd);
        apb_access(1'b1, `PD_REG_STATUS, rnd);
        apb_access(1'b1, `PD_REG_ACTION, 32'h3);
        apb_access(1'b1, `PD_REG_CTRL, 32'h1);
        repeat (200) @(posedge clk_input_data);  // Still above the brows
        apb_access(1'b1, `PD_REG_STATUS, ~rnd & 32'hf);
        wait_frame(1'b0);
        apb_access(1'b0, `PD_REG_STATUS, ~rnd & 32'hf);

        test_name = "random_ready";
        random_bits(6, rnd);
        apb_access(1'b1, `PD_REG_STATUS, rnd & 32'hf);
        apb_access(1'b1, `PD_REG_ACTION, (rnd >> 4) & 32'h3);
        apb_access(1'b1, `PD_REG_CTRL, 32'h1);
        repeat (50) @(posedge clk_input_data);
        test_name = "busy_start_and_bad_addr";
        apb_access(1'b1, `PD_REG_CTRL, 32'h1);  // Must not restart the count
        apb_access(1'b0, `PD_REG_CTRL, 32'h1);
        apb_access(1'b1, 4'hc, 32'h5);
        apb_access(1'b0, 4'hc, 32'h0);
        test_name = "random_ready";
        wait_frame(1'b1);
        apb_access(1'b0, `PD_REG_CTRL, 32'h0);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
